/* Bender.yml */
package:
  name: tiny_cpu

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/isa_pkg.sv
      - verilog/core_pkg.sv
      - verilog/cpu_core.sv
      - verilog/word_memory.sv
      - verilog/out_port.sv
      - verilog/tiny_cpu_top.sv

  - target: test
    include_dirs:
      - verilog
    files:
      - tests/tiny_cpu_tb.sv

/* tests/tiny_cpu_tb.sv */
// testbench for the tiny cpu that runs small programs against a credit-based sink.
`timescale 1ns/1ns
`include "tiny_cpu_macros.svh"

module tiny_cpu_tb import isa_pkg::*, core_pkg::*; ();
    localparam int N_TESTS     = 7;
    localparam int CLK_NS      = 20;
    localparam int HOLD_CYCLES = 40; // credits withheld after start.

    logic      clk;
    logic      rst;
    logic      start;
    logic      load_en;
    mem_addr_t load_addr;
    word_t     load_data;
    logic      sink_credit;
    logic      sink_valid;
    word_t     sink_data;
    logic      halted;

    word_t progs [N_TESTS][`MEM_WORDS];
    int    prog_len [N_TESTS];
    int    hold_for [N_TESTS];
    string test_name [N_TESTS];

    word_t exp_q [$];
    word_t got_q [$];
    time   got_t_q [$];
    int    due_q [$]; // cycles at which credits go back.

    int     cyc;
    int     last_due;
    int     hold_left;
    int     sent;
    int     returned;
    int     errors;
    int     checks;
    int     failed_tests;
    logic   started;
    logic   credit_next;
    logic   build_done = 1'b0;
    integer seed = 32'hfaff6b62;

    tiny_cpu_top uut (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .sink_credit (sink_credit),
        .sink_valid  (sink_valid),
        .sink_data   (sink_data),
        .halted      (halted)
    );

    initial clk = 1'b0;
    always #(CLK_NS / 2) clk = ~clk;

    // ======================================================================
    // instruction encoding
    // ======================================================================
    function automatic word_t encode(logic [6:0] op, reg_idx_t rd, logic [2:0] f3,
                                     reg_idx_t rs1, reg_idx_t rs2, imm7_t imm);
        return {imm, rs2, rs1, f3, rd, op};
    endfunction

    function automatic word_t emit_imm(imm7_t imm);
        return encode(OP_OUT, '0, '0, '0, '0, imm);
    endfunction

    function automatic word_t load_imm(reg_idx_t rd, imm7_t imm);
        return encode(OP_LI, rd, '0, '0, '0, imm);
    endfunction

    function automatic word_t emit_reg(reg_idx_t rd);
        return encode(OP_OUTR, rd, '0, '0, '0, '0);
    endfunction

    function automatic word_t emit_loc(logic [4:0] idx);
        return encode(OP_OUTLOC, '0, '0, '0, '0, {idx, 2'b00});
    endfunction

    function automatic word_t add_imm(reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
        return encode(OP_OPIMM, rd, ADDI, rs1, imm[4:0], imm[11:5]);
    endfunction

    function automatic word_t store_reg(reg_idx_t rs2, reg_idx_t rs1, logic [11:0] off);
        return encode(OP_STORE, off[4:0], 3'b010, rs1, rs2, off[11:5]);
    endfunction

    function automatic word_t halt_insn();
        return encode(OP_HALT, '0, '0, '0, '0, '0);
    endfunction

    // unknown opcode in the low bits, address spread over bits 13:8.
    function automatic word_t fill_word(input int a);
        return 32'hc0de_0000 | (word_t'(a) << 8) | 32'h7f;
    endfunction

    task automatic append(input int t, input word_t w);
        progs[t][prog_len[t]] = w;
        prog_len[t]++;
    endtask

    // ======================================================================
    // programs
    // ======================================================================
    task automatic build_programs();
        imm7_t       r7;
        logic [11:0] r12;
        for (int t = 0; t < N_TESTS; t++) begin
            prog_len[t] = 0;
            hold_for[t] = 0;
            for (int a = 0; a < `MEM_WORDS; a++) begin
                progs[t][a] = fill_word(a);
            end
        end
        test_name[0] = "out_sequence";
        append(0, emit_imm(7'd5));
        append(0, emit_imm(7'd0));
        append(0, emit_imm(7'd127));
        append(0, emit_imm(7'd64));
        append(0, emit_imm(7'd1));
        append(0, emit_imm(7'd99));
        append(0, halt_insn());

        test_name[1] = "reg_arith";
        append(1, load_imm(5'd1, 7'd100));
        append(1, add_imm(5'd2, 5'd1, 12'hfff)); // 99.
        append(1, add_imm(5'd3, 5'd0, 12'h800)); // most negative immediate.
        append(1, add_imm(5'd4, 5'd3, 12'h7ff)); // -1.
        append(1, add_imm(5'd5, 5'd4, 12'h001)); // wraps to zero.
        append(1, add_imm(5'd0, 5'd1, 12'h005));
        append(1, load_imm(5'd0, 7'd77));
        for (int i = 0; i <= 5; i++) begin
            append(1, emit_reg(reg_idx_t'(i)));
        end
        append(1, add_imm(5'd6, 5'd4, 12'hffb));
        append(1, emit_reg(5'd6));
        r7  = imm7_t'($random(seed));
        r12 = 12'($random(seed));
        append(1, load_imm(5'd7, r7));
        append(1, add_imm(5'd8, 5'd7, r12));
        append(1, emit_reg(5'd8));
        append(1, halt_insn());

        // data words live at 24 to 31, above the code.
        test_name[2] = "store_outloc";
        append(2, load_imm(5'd1, 7'd100));
        append(2, load_imm(5'd2, 7'd55));
        append(2, add_imm(5'd3, 5'd0, 12'hfff));
        append(2, add_imm(5'd4, 5'd2, 12'd1000));
        append(2, add_imm(5'd5, 5'd0, 12'hff8));
        append(2, store_reg(5'd2, 5'd1, 12'hffc)); // word 24.
        append(2, store_reg(5'd3, 5'd1, 12'd0));
        append(2, store_reg(5'd4, 5'd1, 12'd8));
        append(2, store_reg(5'd1, 5'd1, 12'd23));  // low bits dropped.
        append(2, store_reg(5'd2, 5'd5, 12'd124)); // negative base.
        append(2, emit_loc(5'd24));
        append(2, emit_loc(5'd25));
        append(2, emit_loc(5'd27));
        append(2, emit_loc(5'd30));
        append(2, emit_loc(5'd29));
        append(2, emit_loc(5'd26)); // never stored.
        append(2, halt_insn());

        test_name[3] = "credit_hold";
        hold_for[3] = HOLD_CYCLES;
        append(3, load_imm(5'd9, 7'd33));
        for (int i = 0; i < 6; i++) begin
            append(3, emit_imm(imm7_t'($random(seed))));
        end
        append(3, emit_reg(5'd9));
        append(3, emit_loc(5'd0)); // reads back its own first word.
        append(3, halt_insn());

        test_name[4] = "halt_stop";
        append(4, emit_imm(7'd11));
        append(4, emit_imm(7'd22));
        append(4, emit_imm(7'd33));
        append(4, halt_insn());
        append(4, emit_imm(7'd44));
        append(4, emit_imm(7'd55));

        test_name[5] = "bad_opcode";
        append(5, emit_imm(7'd7));
        append(5, load_imm(5'd1, 7'd9));
        append(5, emit_reg(5'd1));
        append(5, encode(7'h7f, 5'd3, 3'd0, 5'd0, 5'd0, 7'h12));
        append(5, emit_imm(7'd1));

        test_name[6] = "bad_funct";
        append(6, emit_imm(7'd3));
        append(6, encode(OP_OPIMM, 5'd1, 3'b001, 5'd0, 5'd5, 7'd0));
        append(6, emit_imm(7'd4));
    endtask

    // ======================================================================
    // reference model of the instruction set
    // ======================================================================
    task automatic run_reference(input int t);
        word_t       mem [`MEM_WORDS];
        word_t       r [`REG_COUNT];
        word_t       w;
        word_t       ea;
        logic [6:0]  op;
        reg_idx_t    rd;
        reg_idx_t    rs1;
        reg_idx_t    rs2;
        imm7_t       imm;
        logic [11:0] i12;
        logic [11:0] s12;
        int          pc;
        int          steps;
        logic        done;
        for (int a = 0; a < `MEM_WORDS; a++) begin
            mem[a] = progs[t][a];
        end
        for (int i = 0; i < `REG_COUNT; i++) begin
            r[i] = '0;
        end
        exp_q.delete();
        pc    = 0;
        steps = 0;
        done  = 1'b0;
        while (!done && steps < 256) begin
            w   = mem[pc];
            op  = w[6:0];
            rd  = w[11:7];
            rs1 = w[19:15];
            rs2 = w[24:20];
            imm = w[31:25];
            i12 = {imm, rs2};
            s12 = {imm, rd};
            case (op)
                OP_OUT:    exp_q.push_back({25'd0, imm});
                OP_OUTLOC: exp_q.push_back(mem[imm[6:2]]);
                OP_LI:     r[rd] = {25'd0, imm};
                OP_OUTR:   exp_q.push_back(r[rd]);
                OP_STORE: begin
                    ea = r[rs1] + {{20{s12[11]}}, s12};
                    mem[int'((ea >> 2) % `MEM_WORDS)] = r[rs2];
                end
                OP_OPIMM: begin
                    if (w[14:12] == 3'b000) begin
                        r[rd] = r[rs1] + {{20{i12[11]}}, i12};
                    end else begin
                        done = 1'b1;
                    end
                end
                default: done = 1'b1;
            endcase
            r[0]  = '0;
            pc    = (pc + 1) % `MEM_WORDS;
            steps++;
        end
    endtask

    // ======================================================================
    // credit sink model
    // ======================================================================
    always @(posedge clk) begin
        int delay;
        int due;
        credit_next = 1'b0;
        if (!rst) begin
            cyc++;
            if (sink_credit) begin
                returned++;
            end
            if (sink_valid) begin
                sent++;
                got_q.push_back(sink_data);
                got_t_q.push_back($time);
                delay = $unsigned($random(seed)) % 6;
                due   = cyc + 1 + delay;
                if (due <= last_due) begin
                    due = last_due + 1; // one credit per cycle.
                end
                last_due = due;
                due_q.push_back(due);
            end
            if (hold_left > 0) begin
                hold_left--;
            end else if (due_q.size() > 0 && due_q[0] <= cyc) begin
                void'(due_q.pop_front());
                credit_next = 1'b1;
            end
        end
        #2;
        sink_credit = credit_next;
    end

    // ======================================================================
    // protocol checks
    // ======================================================================
    assert property (@(posedge clk) disable iff (rst) !started |-> (!sink_valid && !halted))
        else begin
            errors++;
            $display("ERROR at %0t: sink_valid or halted went high before start", $time);
        end

    assert property (@(posedge clk) disable iff (rst) halted |=> halted)
        else begin
            errors++;
            $display("ERROR at %0t: halted dropped without a reset", $time);
        end

    assert property (@(posedge clk) disable iff (rst) sent <= `OUT_CREDITS + returned)
        else begin
            errors++;
            $display("ERROR at %0t: %0d words sent on %0d credits", $time, sent,
                     `OUT_CREDITS + returned);
        end

    assert property (@(posedge clk) disable iff (rst) sink_valid |-> !$isunknown(sink_data))
        else begin
            errors++;
            $display("ERROR at %0t: sink_data unknown while sink_valid is high", $time);
        end

    // ======================================================================
    // test sequencing
    // ======================================================================
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic apply_reset();
        next_cycle();
        rst       = 1'b1;
        start     = 1'b0;
        load_en   = 1'b0;
        started   = 1'b0;
        hold_left = 0;
        sent      = 0;
        returned  = 0;
        last_due  = 0;
        got_q.delete();
        got_t_q.delete();
        due_q.delete();
        repeat (3) @(posedge clk);
        #2;
        rst = 1'b0;
        checks++;
        assert (!sink_valid && !halted)
            else begin
                errors++;
                $display("ERROR at %0t: sink_valid or halted high after reset", $time);
            end
    endtask

    task automatic load_program(input int t);
        for (int a = 0; a < `MEM_WORDS; a++) begin
            next_cycle();
            load_en   = 1'b1;
            load_addr = mem_addr_t'(a);
            load_data = progs[t][a];
        end
        next_cycle();
        load_en = 1'b0;
    endtask

    task automatic compare_words();
        checks++;
        assert (got_q.size() == exp_q.size())
            else begin
                errors++;
                $display("MISMATCH at %0t: sink word count got %0d expected %0d",
                         $time, got_q.size(), exp_q.size());
            end
        for (int i = 0; i < exp_q.size() && i < got_q.size(); i++) begin
            checks++;
            assert (got_q[i] === exp_q[i])
                else begin
                    errors++;
                    $display("MISMATCH at %0t: sink_data word %0d got %h expected %h",
                             got_t_q[i], i, got_q[i], exp_q[i]);
                end
        end
    endtask

    task automatic run_test(input int t);
        int err_before;
        int limit;
        int n;
        err_before = errors;
        apply_reset();
        load_program(t);
        run_reference(t);
        next_cycle();
        hold_left = hold_for[t];
        start     = 1'b1;
        started   = 1'b1;
        next_cycle();
        start = 1'b0;
        limit = prog_len[t] * 20 + hold_for[t] + 50;
        n = 0;
        while (!halted && n < limit) begin
            next_cycle();
            n++;
        end
        checks++;
        assert (halted)
            else begin
                errors++;
                $display("ERROR at %0t: halted never rose in test %0d", $time, t);
            end
        // let queued words drain and credits come home.
        n = 0;
        while ((got_q.size() < exp_q.size() || due_q.size() != 0) && n < limit) begin
            next_cycle();
            n++;
        end
        repeat (10) next_cycle();
        n = 0;
        while (due_q.size() != 0 && n < limit) begin
            next_cycle();
            n++;
        end
        compare_words();
        if (errors != err_before) begin
            failed_tests++;
        end
        $display("test %0d %-13s %s, %0d words", t, test_name[t],
                 (errors == err_before) ? "ok" : "failed", got_q.size());
    endtask

    initial begin
        rst          = 1'b1;
        start        = 1'b0;
        load_en      = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        sink_credit  = 1'b0;
        started      = 1'b0;
        cyc          = 0;
        last_due     = 0;
        hold_left    = 0;
        sent         = 0;
        returned     = 0;
        errors       = 0;
        checks       = 0;
        failed_tests = 0;
        build_programs();
        build_done = 1'b1;
        for (int t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 N_TESTS, failed_tests, checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // watchdog sized from program lengths plus load and drain time.
    initial begin
        int total;
        wait (build_done);
        total = 0;
        for (int t = 0; t < N_TESTS; t++) begin
            total += prog_len[t] * 20 + hold_for[t] + `MEM_WORDS + 100;
        end
        #(total * CLK_NS);
        $display("ERROR: watchdog expired after %0d cycles, run did not finish", total);
        $display(">>> FAIL");
        $finish;
    end

endmodule

/* tiny_cpu_top.f */
+incdir+verilog
verilog/isa_pkg.sv
verilog/core_pkg.sv
verilog/cpu_core.sv
verilog/word_memory.sv
verilog/out_port.sv
verilog/tiny_cpu_top.sv
tests/tiny_cpu_tb.sv

/* verilog/core_pkg.sv */
// micro-architecture types: core FSM states, memory and queue indices.
`include "tiny_cpu_macros.svh"

package core_pkg;

    // sequencer states of the core.
    typedef enum logic [2:0] {
        S_IDLE,  // waiting for start.
        S_FETCH, // issue instruction read.
        S_EXEC,  // wait for fetch ack, execute.
        S_MEM,   // second access of store/outloc.
        S_EMIT,  // stalled on a full output queue.
        S_HALT
    } core_state_e;

    // word index into the unified memory.
    typedef logic [$clog2(`MEM_WORDS)-1:0] mem_addr_t;

    // queue occupancy and sink credits, 0 to OUT_DEPTH inclusive.
    typedef logic [$clog2(`OUT_DEPTH+1)-1:0] out_cnt_t;

endpackage

/* verilog/cpu_core.sv */
// cpu core: sequential fetch/execute FSM with a 32-entry register file.
`timescale 1ns/1ns
`include "tiny_cpu_macros.svh"

module cpu_core import isa_pkg::*, core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  word_t     mem_rd_data,
    input  logic      mem_ack,
    input  logic      mem_busy,
    input  logic      out_ready,
    output mem_addr_t mem_addr,
    output word_t     mem_wr_data,
    output logic      mem_rd_req,
    output logic      mem_wr_req,
    output logic      out_push,
    output word_t     out_data,
    output logic      halted
);
    word_t       regs [`REG_COUNT];
    core_state_e state;
    mem_addr_t   pc;
    opcode_e     op_q; // op waiting in S_MEM.

    opcode_e     op;
    funct_e      funct;
    reg_idx_t    rd;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    imm7_t       imm7;
    logic [11:0] imm12;
    logic [11:0] st_off;
    word_t       rs1_val;
    word_t       rs2_val;
    word_t       rd_val;
    word_t       addi_sum;
    word_t       st_sum;
    mem_addr_t   st_addr;
    word_t       emit_val;
    logic        exec;
    logic        is_emit;
    logic        known_op;
    logic        rf_we;
    word_t       rf_wdata;

    // ==================================================================
    // decode, straight off the fetch data in the ack cycle
    // ==================================================================
    assign exec  = (state == S_EXEC) && mem_ack;
    assign op    = opcode_e'(mem_rd_data[6:0]);
    assign rd    = mem_rd_data[11:7];
    assign funct = funct_e'(mem_rd_data[14:12]);
    assign rs1   = mem_rd_data[19:15];
    assign rs2   = mem_rd_data[24:20];
    assign imm7  = mem_rd_data[31:25];

    assign imm12  = {imm7, rs2};
    assign st_off = {imm7, rd}; // s-type split immediate.

    // x0 reads as zero whatever the array holds.
    assign rs1_val = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_val = (rs2 == '0) ? '0 : regs[rs2];
    assign rd_val  = (rd == '0) ? '0 : regs[rd];

    assign addi_sum = rs1_val + {{(`XLEN-12){imm12[11]}}, imm12};
    assign st_sum   = rs1_val + {{(`XLEN-12){st_off[11]}}, st_off};
    assign st_addr  = mem_addr_t'(st_sum >> 2); // byte address to word index.

    assign is_emit  = (op == OP_OUT) || (op == OP_OUTR);
    assign emit_val = (op == OP_OUT) ? word_t'(imm7) : rd_val;

    always_comb begin
        case (op)
            OP_OUT, OP_OUTLOC, OP_LI, OP_OUTR, OP_STORE: known_op = 1'b1;
            OP_OPIMM: known_op = (funct == ADDI);
            default:  known_op = 1'b0; // halt and anything unknown.
        endcase
    end

    assign rf_we = exec && (rd != '0) &&
                   ((op == OP_LI) || (op == OP_OPIMM && funct == ADDI));
    assign rf_wdata = (op == OP_LI) ? word_t'(imm7) : addi_sum;

    // ==================================================================
    // control FSM
    // ==================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= S_IDLE;
            pc         <= '0;
            op_q       <= OP_HALT;
            mem_rd_req <= 1'b0;
            mem_wr_req <= 1'b0;
            out_push   <= 1'b0;
            halted     <= 1'b0;
        end else begin
            mem_rd_req <= 1'b0; // requests are single pulses.
            mem_wr_req <= 1'b0;
            out_push   <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        pc    <= '0;
                        state <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    if (!mem_busy) begin
                        mem_rd_req <= 1'b1;
                        state      <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    if (mem_ack) begin
                        op_q <= op;
                        if (!known_op) begin
                            halted <= 1'b1;
                            state  <= S_HALT;
                        end else if (op == OP_STORE) begin
                            mem_wr_req <= 1'b1;
                            state      <= S_MEM;
                        end else if (op == OP_OUTLOC) begin
                            mem_rd_req <= 1'b1;
                            state      <= S_MEM;
                        end else if (is_emit && !out_ready) begin
                            state <= S_EMIT;
                        end else begin
                            out_push <= is_emit;
                            pc       <= pc + mem_addr_t'(1);
                            state    <= S_FETCH;
                        end
                    end
                end
                S_MEM: begin
                    if (mem_ack) begin
                        if (op_q == OP_OUTLOC && !out_ready) begin
                            state <= S_EMIT;
                        end else begin
                            out_push <= (op_q == OP_OUTLOC);
                            pc       <= pc + mem_addr_t'(1);
                            state    <= S_FETCH;
                        end
                    end
                end
                S_EMIT: begin
                    if (out_ready) begin // queue has room again.
                        out_push <= 1'b1;
                        pc       <= pc + mem_addr_t'(1);
                        state    <= S_FETCH;
                    end
                end
                S_HALT: ;
                default: state <= S_IDLE;
            endcase
        end
    end

    // ==================================================================
    // datapath registers and register file
    // ==================================================================
    always_ff @(posedge clk) begin
        if (state == S_FETCH) begin
            mem_addr <= pc;
        end else if (exec && op == OP_STORE) begin
            mem_addr    <= st_addr;
            mem_wr_data <= rs2_val;
        end else if (exec && op == OP_OUTLOC) begin
            mem_addr <= mem_addr_t'(imm7[6:2]);
        end

        if (exec && is_emit) begin
            out_data <= emit_val;
        end else if (state == S_MEM && mem_ack && op_q == OP_OUTLOC) begin
            out_data <= mem_rd_data;
        end

        if (rf_we) begin
            regs[rd] <= rf_wdata;
        end
    end

endmodule

/* verilog/isa_pkg.sv */
// isa types: opcode and funct encodings plus instruction field widths.
`include "tiny_cpu_macros.svh"

package isa_pkg;

    // data word as held in registers and memory.
    typedef logic [`XLEN-1:0] word_t;

    // ==================================================================
    // encodings
    // ==================================================================

    // custom opcodes live in the low values.
    typedef enum logic [6:0] {
        OP_OUT    = 7'd1,
        OP_OUTLOC = 7'd2,
        OP_LI     = 7'd3,
        OP_OUTR   = 7'd4,
        OP_HALT   = 7'd5,
        OP_STORE  = 7'b0100011, // sw rs2, offset(rs1).
        OP_OPIMM  = 7'b0010011
    } opcode_e;

    // only addi is decoded under op-imm.
    typedef enum logic [2:0] {
        ADDI = 3'b000
    } funct_e;

    // ==================================================================
    // fields
    // ==================================================================

    // rd, rs1 and rs2 slots.
    typedef logic [4:0] reg_idx_t;

    // bits 31:25, the upper immediate.
    typedef logic [6:0] imm7_t;

endpackage

/* verilog/out_port.sv */
// output port: word queue draining to a credit-based sink.
`timescale 1ns/1ns
`include "tiny_cpu_macros.svh"

module out_port import isa_pkg::*, core_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  push,
    input  word_t push_data,
    input  logic  sink_credit,
    output logic  ready,
    output logic  sink_valid,
    output word_t sink_data
);
    localparam int PTR_W = $clog2(`OUT_DEPTH);

    word_t            q [`OUT_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    out_cnt_t         count;
    out_cnt_t         credits;
    logic             push_ok;
    logic             send;

    assign ready   = (count != out_cnt_t'(`OUT_DEPTH));
    assign push_ok = push && ready;
    assign send    = (count != '0) && (credits != '0); // head word and a slot.

    // ==================================================================
    // pointers, occupancy and credits
    // ==================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credits    <= out_cnt_t'(`OUT_CREDITS);
            sink_valid <= 1'b0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (send) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            count      <= count + out_cnt_t'(push_ok) - out_cnt_t'(send);
            credits    <= credits + out_cnt_t'(sink_credit) - out_cnt_t'(send);
            sink_valid <= send;
        end
    end

    always_ff @(posedge clk) begin
        if (push_ok) begin
            q[wr_ptr] <= push_data;
        end
        if (send) begin
            sink_data <= q[rd_ptr];
        end
    end

endmodule

/* verilog/tiny_cpu_macros.svh */
// tiny cpu sizing constants shared by the packages and the RTL blocks.
`ifndef TINY_CPU_MACROS_SVH
`define TINY_CPU_MACROS_SVH

// ======================================================================
// datapath
// ======================================================================

// data word width.
`define XLEN 32

// architectural registers, x0 reads as zero.
`define REG_COUNT 32

// ======================================================================
// memory
// ======================================================================

// depth of the unified word memory.
`define MEM_WORDS 64

// cycles from request to ack.
`define MEM_LATENCY 2

// ======================================================================
// output path
// ======================================================================

`define OUT_DEPTH 4   // output queue entries.
`define OUT_CREDITS 2 // sink slots granted at reset.

`endif

/* verilog/tiny_cpu_top.sv */
// tiny cpu top: core beside the word memory and the output port.
`timescale 1ns/1ns
`include "tiny_cpu_macros.svh"

module tiny_cpu_top import isa_pkg::*, core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  logic      load_en,
    input  mem_addr_t load_addr,
    input  word_t     load_data,
    input  logic      sink_credit,
    output logic      sink_valid,
    output word_t     sink_data,
    output logic      halted
);
    // core to memory.
    mem_addr_t mem_addr;
    word_t     mem_wr_data;
    word_t     mem_rd_data;
    logic      mem_rd_req;
    logic      mem_wr_req;
    logic      mem_ack;
    logic      mem_busy;

    // core to output queue.
    logic      out_push;
    word_t     out_data;
    logic      out_ready;

    cpu_core u_core (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .mem_rd_data (mem_rd_data),
        .mem_ack     (mem_ack),
        .mem_busy    (mem_busy),
        .out_ready   (out_ready),
        .mem_addr    (mem_addr),
        .mem_wr_data (mem_wr_data),
        .mem_rd_req  (mem_rd_req),
        .mem_wr_req  (mem_wr_req),
        .out_push    (out_push),
        .out_data    (out_data),
        .halted      (halted)
    );

    word_memory u_mem (
        .clk       (clk),
        .rst       (rst),
        .addr      (mem_addr),
        .wr_data   (mem_wr_data),
        .rd_req    (mem_rd_req),
        .wr_req    (mem_wr_req),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_data   (mem_rd_data),
        .ack       (mem_ack),
        .busy      (mem_busy)
    );

    out_port u_out (
        .clk         (clk),
        .rst         (rst),
        .push        (out_push),
        .push_data   (out_data),
        .sink_credit (sink_credit),
        .ready       (out_ready),
        .sink_valid  (sink_valid),
        .sink_data   (sink_data)
    );

endmodule

/* verilog/word_memory.sv */
// word memory: fixed-latency request/ack RAM with a direct load port.
`timescale 1ns/1ns
`include "tiny_cpu_macros.svh"

module word_memory import isa_pkg::*, core_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  mem_addr_t addr,
    input  word_t     wr_data,
    input  logic      rd_req,
    input  logic      wr_req,
    input  logic      load_en,
    input  mem_addr_t load_addr,
    input  word_t     load_data,
    output word_t     rd_data,
    output logic      ack,
    output logic      busy
);
    localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

    word_t      mem [`MEM_WORDS];
    logic [CNT_W-1:0] cnt; // cycles left until ack.
    logic       we_q;      // outstanding access is a write.
    mem_addr_t  addr_q;
    word_t      data_q;
    logic       req;

    assign req = rd_req || wr_req;

    // ack in the last countdown cycle; busy drops there so the next
    // request may follow right after.
    assign ack  = (cnt == CNT_W'(1));
    assign busy = (cnt > CNT_W'(1));

    // read returns the captured word, valid in the ack cycle.
    assign rd_data = mem[addr_q];

    // ==================================================================
    // latency countdown
    // ==================================================================
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt  <= '0;
            we_q <= 1'b0;
        end else if (req) begin
            cnt  <= CNT_W'(`MEM_LATENCY);
            we_q <= wr_req;
        end else if (cnt != '0) begin
            cnt <= cnt - CNT_W'(1);
        end
    end

    // ==================================================================
    // storage
    // ==================================================================
    always_ff @(posedge clk) begin
        if (req) begin
            addr_q <= addr;
            data_q <= wr_data;
        end

        // program load has priority, core is idle then anyway.
        if (load_en) begin
            mem[load_addr] <= load_data;
        end else if (ack && we_q) begin
            mem[addr_q] <= data_q; // write lands at ack.
        end
    end

endmodule
